/* design/flow_table_pkg.sv */
`default_nettype none

package flow_table_pkg;

    localparam int KEY_W     = 32;
    localparam int QID_W     = 8;

    // Table geometry
    localparam int FT_WAYS   = 4;
    localparam int FT_AWIDTH = 3;
    localparam int FT_DEPTH  = 8;

    // Entry is {valid, key, qid}
    localparam int ENTRY_W   = 1 + KEY_W + QID_W;

    // One odd multiplier per way, way 0 in the low word
    localparam logic [FT_WAYS-1:0][31:0] HASH_MULT = {
        32'h27D4EB2F, 32'hC2B2AE3D, 32'h85EBCA77, 32'h9E3779B1
    };

    localparam logic [QID_W-1:0] QID_DROP = '1;

    // Placement FSM encoding
    localparam logic [1:0] ST_IDLE   = 2'd0;
    localparam logic [1:0] ST_READ   = 2'd1;
    localparam logic [1:0] ST_DECIDE = 2'd2;
    localparam logic [1:0] ST_WRITE  = 2'd3;

endpackage

`default_nettype wire

/* design/flow_table_if.sv */
`timescale 1ns/1ns
`default_nettype none

interface flow_table_if;

    // Per-way indices and read data, way 0 in the low bits
    logic [flow_table_pkg::FT_WAYS*flow_table_pkg::FT_AWIDTH-1:0] addr;
    logic                                                       rden;
    logic [flow_table_pkg::FT_WAYS-1:0]                         wr_way;
    logic [flow_table_pkg::ENTRY_W-1:0]                         wdata;
    logic [flow_table_pkg::FT_WAYS*flow_table_pkg::ENTRY_W-1:0]   rdata;

    modport lookup (output addr, rden, input rdata);
    modport place (output addr, rden, wr_way, wdata, input rdata);

    // Memory side
    modport ram_read (input addr, rden, output rdata);
    modport ram_write (input addr, rden, wr_way, wdata, output rdata);

endinterface

`default_nettype wire

/* design/key_hasher.sv */
`timescale 1ns/1ns
`default_nettype none

module key_hasher (
    input  logic                                                       clk,
    input  logic                                                       rst,
    input  logic                                                       in_valid,
    input  logic [flow_table_pkg::KEY_W-1:0]                           in_key,
    output logic                                                       out_valid,
    output logic [flow_table_pkg::KEY_W-1:0]                           out_key,
    output logic [flow_table_pkg::FT_WAYS*flow_table_pkg::FT_AWIDTH-1:0] out_idx
);

    localparam int AW = flow_table_pkg::FT_AWIDTH;

    logic [flow_table_pkg::FT_WAYS*AW-1:0] idx_next;

    // Index is the top bits of the truncated product
    for (genvar w = 0; w < flow_table_pkg::FT_WAYS; w++) begin : g_way
        logic [31:0] prod;
        assign prod = in_key * flow_table_pkg::HASH_MULT[w];
        assign idx_next[w*AW +: AW] = prod[31 -: AW];
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid) begin
            out_key <= in_key;
            out_idx <= idx_next;
        end
    end

endmodule

`default_nettype wire

/* design/flow_table_ram.sv */
`timescale 1ns/1ns
`default_nettype none

module flow_table_ram (
    input  logic            clk,
    input  logic            rst,
    flow_table_if.ram_read  rd_port,
    flow_table_if.ram_write rw_port
);

    localparam int AW = flow_table_pkg::FT_AWIDTH;
    localparam int EW = flow_table_pkg::ENTRY_W;

    logic [AW-1:0] clr_row;

    // Walks every row while reset is held
    always_ff @(posedge clk) begin
        if (rst) begin
            clr_row <= clr_row + 1'b1;
        end else begin
            clr_row <= '0;
        end
    end

    for (genvar w = 0; w < flow_table_pkg::FT_WAYS; w++) begin : g_way
        logic [EW-1:0] mem [flow_table_pkg::FT_DEPTH];
        logic [AW-1:0] rd_idx;
        logic [AW-1:0] rw_idx;
        logic [EW-1:0] rd_q;
        logic [EW-1:0] rw_q;

        assign rd_idx = rd_port.addr[w*AW +: AW];
        assign rw_idx = rw_port.addr[w*AW +: AW];

        always_ff @(posedge clk) begin
            if (rst) begin
                mem[clr_row] <= '0;
            end else if (rw_port.wr_way[w]) begin
                mem[rw_idx] <= rw_port.wdata;
            end
        end

        // Read-before-write on both ports
        always_ff @(posedge clk) begin
            if (rd_port.rden) begin
                rd_q <= mem[rd_idx];
            end
            if (rw_port.rden) begin
                rw_q <= mem[rw_idx];
            end
        end

        assign rd_port.rdata[w*EW +: EW] = rd_q;
        assign rw_port.rdata[w*EW +: EW] = rw_q;
    end

endmodule

`default_nettype wire

/* design/lookup_matcher.sv */
`timescale 1ns/1ns
`default_nettype none

module lookup_matcher (
    input  logic                                                       clk,
    input  logic                                                       rst,
    input  logic                                                       hash_valid,
    input  logic [flow_table_pkg::KEY_W-1:0]                           hash_key,
    input  logic [flow_table_pkg::FT_WAYS*flow_table_pkg::FT_AWIDTH-1:0] hash_idx,
    flow_table_if.lookup                                               bus,
    output logic                                                       result_valid,
    output logic [flow_table_pkg::KEY_W-1:0]                           result_key,
    output logic [flow_table_pkg::QID_W-1:0]                           result_qid
);

    localparam int EW = flow_table_pkg::ENTRY_W;
    localparam int QW = flow_table_pkg::QID_W;

    logic                               rd_valid;
    logic [flow_table_pkg::KEY_W-1:0]   rd_key;
    logic [flow_table_pkg::FT_WAYS-1:0] hit;
    logic [QW-1:0]                      way_qid [flow_table_pkg::FT_WAYS];
    logic [QW-1:0]                      match_qid;

    assign bus.rden = hash_valid;
    assign bus.addr = hash_idx;

    always_ff @(posedge clk) begin
        if (rst) begin
            rd_valid <= 1'b0;
        end else begin
            rd_valid <= hash_valid;
        end
    end

    // Key rides along with the RAM read
    always_ff @(posedge clk) begin
        if (hash_valid) begin
            rd_key <= hash_key;
        end
    end

    for (genvar w = 0; w < flow_table_pkg::FT_WAYS; w++) begin : g_way
        logic [EW-1:0] entry;
        assign entry = bus.rdata[w*EW +: EW];
        assign hit[w] = entry[EW-1] && (entry[QW +: flow_table_pkg::KEY_W] == rd_key);
        assign way_qid[w] = entry[QW-1:0];
    end

    // Lowest matching way wins
    always_comb begin
        match_qid = flow_table_pkg::QID_DROP;
        for (int w = flow_table_pkg::FT_WAYS - 1; w >= 0; w--) begin
            if (hit[w]) begin
                match_qid = way_qid[w];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            result_valid <= 1'b0;
        end else begin
            result_valid <= rd_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (rd_valid) begin
            result_key <= rd_key;
            result_qid <= match_qid;
        end
    end

endmodule

`default_nettype wire

/* design/flow_placer.sv */
`timescale 1ns/1ns
`default_nettype none

module flow_placer (
    input  logic                                                       clk,
    input  logic                                                       rst,
    input  logic                                                       hash_valid,
    input  logic [flow_table_pkg::KEY_W-1:0]                           hash_key,
    input  logic [flow_table_pkg::FT_WAYS*flow_table_pkg::FT_AWIDTH-1:0] hash_idx,
    input  logic                                                       ctrl_valid,
    input  logic [flow_table_pkg::QID_W-1:0]                           ctrl_qid,
    output logic                                                       ctrl_ready,
    flow_table_if.place                                                bus,
    output logic                                                       ctrl_done,
    output logic                                                       ctrl_full
);

    localparam int EW = flow_table_pkg::ENTRY_W;
    localparam int QW = flow_table_pkg::QID_W;
    localparam int NW = flow_table_pkg::FT_WAYS;

    logic [1:0]                             state;
    logic                                   accept;
    logic [QW-1:0]                          qid_r;
    logic [flow_table_pkg::KEY_W-1:0]       key_r;
    logic [NW*flow_table_pkg::FT_AWIDTH-1:0] idx_r;
    logic [NW-1:0]                          hit;
    logic [NW-1:0]                          empty;
    logic [NW-1:0]                          hit_r;
    logic [NW-1:0]                          empty_r;
    logic [NW-1:0]                          way_sel;

    assign accept = ctrl_valid && ctrl_ready;

    // Indices are held from the read through the write
    assign bus.rden   = (state == flow_table_pkg::ST_READ) && hash_valid;
    assign bus.addr   = (state == flow_table_pkg::ST_READ) ? hash_idx : idx_r;
    assign bus.wdata  = {1'b1, key_r, qid_r};
    assign bus.wr_way = (state == flow_table_pkg::ST_WRITE) ? way_sel : '0;

    for (genvar w = 0; w < NW; w++) begin : g_way
        logic [EW-1:0] entry;
        assign entry = bus.rdata[w*EW +: EW];
        assign hit[w] = entry[EW-1] && (entry[QW +: flow_table_pkg::KEY_W] == key_r);
        assign empty[w] = !entry[EW-1];
    end

    // Lowest hit first, else lowest empty slot
    always_comb begin
        if (|hit_r) begin
            way_sel = hit_r & (~hit_r + 1'b1);
        end else begin
            way_sel = empty_r & (~empty_r + 1'b1);
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state      <= flow_table_pkg::ST_IDLE;
            ctrl_ready <= 1'b1;
            ctrl_done  <= 1'b0;
            ctrl_full  <= 1'b0;
        end else begin
            ctrl_done <= 1'b0;
            ctrl_full <= 1'b0;
            if (ctrl_done) begin
                ctrl_ready <= 1'b1;
            end
            case (state)
                flow_table_pkg::ST_IDLE: begin
                    if (accept) begin
                        ctrl_ready <= 1'b0;
                        state      <= flow_table_pkg::ST_READ;
                    end
                end
                flow_table_pkg::ST_READ: begin
                    if (hash_valid) begin
                        state <= flow_table_pkg::ST_DECIDE;
                    end
                end
                flow_table_pkg::ST_DECIDE: begin
                    state <= flow_table_pkg::ST_WRITE;
                end
                default: begin
                    // No hit and no empty slot means nothing was written
                    ctrl_done <= 1'b1;
                    ctrl_full <= ~|way_sel;
                    state     <= flow_table_pkg::ST_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            qid_r <= ctrl_qid;
        end
        if (bus.rden) begin
            key_r <= hash_key;
            idx_r <= hash_idx;
        end
        if (state == flow_table_pkg::ST_DECIDE) begin
            hit_r   <= hit;
            empty_r <= empty;
        end
    end

endmodule

`default_nettype wire

/* design/flow_table.sv */
`timescale 1ns/1ns
`default_nettype none

module flow_table (
    input  logic                             clk,
    input  logic                             rst,
    input  logic                             lookup_valid,
    input  logic [flow_table_pkg::KEY_W-1:0] lookup_key,
    output logic                             result_valid,
    output logic [flow_table_pkg::KEY_W-1:0] result_key,
    output logic [flow_table_pkg::QID_W-1:0] result_qid,
    input  logic                             ctrl_valid,
    output logic                             ctrl_ready,
    input  logic [flow_table_pkg::KEY_W-1:0] ctrl_key,
    input  logic [flow_table_pkg::QID_W-1:0] ctrl_qid,
    output logic                             ctrl_done,
    output logic                             ctrl_full
);

    localparam int IW = flow_table_pkg::FT_WAYS * flow_table_pkg::FT_AWIDTH;

    logic                             lk_valid;
    logic [flow_table_pkg::KEY_W-1:0] lk_key;
    logic [IW-1:0]                    lk_idx;
    logic                             pl_valid;
    logic [flow_table_pkg::KEY_W-1:0] pl_key;
    logic [IW-1:0]                    pl_idx;
    logic                             ctrl_accept;

    flow_table_if lookup_bus ();
    flow_table_if place_bus ();

    assign ctrl_accept = ctrl_valid && ctrl_ready;

    key_hasher lookup_hasher (
        .clk(clk), .rst(rst), .in_valid(lookup_valid), .in_key(lookup_key),
        .out_valid(lk_valid), .out_key(lk_key), .out_idx(lk_idx)
    );

    key_hasher place_hasher (
        .clk(clk), .rst(rst), .in_valid(ctrl_accept), .in_key(ctrl_key),
        .out_valid(pl_valid), .out_key(pl_key), .out_idx(pl_idx)
    );

    lookup_matcher matcher (
        .clk(clk), .rst(rst), .hash_valid(lk_valid), .hash_key(lk_key),
        .hash_idx(lk_idx), .bus(lookup_bus.lookup), .result_valid(result_valid),
        .result_key(result_key), .result_qid(result_qid)
    );

    flow_placer placer (
        .clk(clk), .rst(rst), .hash_valid(pl_valid), .hash_key(pl_key),
        .hash_idx(pl_idx), .ctrl_valid(ctrl_valid), .ctrl_qid(ctrl_qid),
        .ctrl_ready(ctrl_ready), .bus(place_bus.place), .ctrl_done(ctrl_done),
        .ctrl_full(ctrl_full)
    );

    // Lookups read one side, placement reads and writes the other
    flow_table_ram ram (
        .clk(clk), .rst(rst), .rd_port(lookup_bus.ram_read),
        .rw_port(place_bus.ram_write)
    );

endmodule

`default_nettype wire

/* tb/flow_table_checker.sv */
`timescale 1ns/1ns
`default_nettype none

module flow_table_checker (
    input logic clk,
    input logic rst,
    input logic lookup_valid,
    input logic result_valid,
    input logic ctrl_valid,
    input logic ctrl_ready,
    input logic ctrl_done,
    input logic ctrl_full
);

    a_done_pulse: assert property (@(posedge clk) disable iff (rst)
        ctrl_done |=> !ctrl_done)
        else $error("ctrl_done stayed high for more than one cycle");

    a_full_with_done: assert property (@(posedge clk) disable iff (rst)
        ctrl_full |-> ctrl_done)
        else $error("ctrl_full raised without ctrl_done");

    // Ready falls after acceptance and stays low until done is seen
    a_ready_drop: assert property (@(posedge clk) disable iff (rst)
        (ctrl_valid && ctrl_ready) |=> !ctrl_ready)
        else $error("ctrl_ready still high after an accepted request");

    a_ready_hold: assert property (@(posedge clk) disable iff (rst)
        (!ctrl_ready && !ctrl_done) |=> !ctrl_ready)
        else $error("ctrl_ready rose before ctrl_done");

    a_ready_at_done: assert property (@(posedge clk) disable iff (rst)
        ctrl_done |-> !ctrl_ready)
        else $error("ctrl_ready high together with ctrl_done");

    a_lookup_latency: assert property (@(posedge clk) disable iff (rst)
        result_valid == $past(lookup_valid, 3))
        else $error("result_valid does not follow lookup_valid by three cycles");

endmodule

bind flow_table flow_table_checker port_checks (
    .clk(clk), .rst(rst), .lookup_valid(lookup_valid), .result_valid(result_valid),
    .ctrl_valid(ctrl_valid), .ctrl_ready(ctrl_ready), .ctrl_done(ctrl_done),
    .ctrl_full(ctrl_full)
);

`default_nettype wire

/* tb/flow_table_tb.sv */
`timescale 1ns/1ns
`default_nettype none

module flow_table_tb;

    localparam int CLK_PERIOD   = 40;
    localparam int RESET_CYCLES = 16;
    localparam int POOL_SIZE    = 48;
    localparam int NUM_ROUNDS   = 250;
    localparam int NUM_TESTS    = 2 * NUM_ROUNDS + 4;
    localparam int KW           = flow_table_pkg::KEY_W;
    localparam int QW           = flow_table_pkg::QID_W;
    localparam int NW           = flow_table_pkg::FT_WAYS;
    localparam int AW           = flow_table_pkg::FT_AWIDTH;

    logic          clk;
    logic          rst;
    logic          lookup_valid;
    logic [KW-1:0] lookup_key;
    logic          result_valid;
    logic [KW-1:0] result_key;
    logic [QW-1:0] result_qid;
    logic          ctrl_valid;
    logic          ctrl_ready;
    logic [KW-1:0] ctrl_key;
    logic [QW-1:0] ctrl_qid;
    logic          ctrl_done;
    logic          ctrl_full;

    integer seed;
    int     cycle = 0;
    int     error_count = 0;
    int     full_count = 0;

    logic [KW-1:0] pool [POOL_SIZE];

    // Reference table, indexed by way then row
    logic          model_valid [NW][flow_table_pkg::FT_DEPTH];
    logic [KW-1:0] model_key [NW][flow_table_pkg::FT_DEPTH];
    logic [QW-1:0] model_qid [NW][flow_table_pkg::FT_DEPTH];

    // Lookups in flight, oldest first
    logic [KW-1:0] exp_key [$];
    logic [QW-1:0] exp_qid [$];
    int            exp_cycle [$];

    flow_table uut (
        .clk(clk), .rst(rst), .lookup_valid(lookup_valid), .lookup_key(lookup_key),
        .result_valid(result_valid), .result_key(result_key), .result_qid(result_qid),
        .ctrl_valid(ctrl_valid), .ctrl_ready(ctrl_ready), .ctrl_key(ctrl_key),
        .ctrl_qid(ctrl_qid), .ctrl_done(ctrl_done), .ctrl_full(ctrl_full)
    );

    initial clk = 1'b0;
    always #(CLK_PERIOD / 2) clk = ~clk;

    always @(posedge clk) begin
        cycle = cycle + 1;
    end

    task automatic end_with_failure();
        error_count = error_count + 1;
        $display("** FAIL **");
        $fatal(1, "Stopped at the first error");
    endtask

    task automatic check_qid(input logic [QW-1:0] expected, input logic [QW-1:0] actual,
                             input string what);
        if (actual !== expected) begin
            $display("CHECK FAILED at %0t ns: %s expected %h, got %h",
                     $time, what, expected, actual);
            end_with_failure();
        end
    endtask

    task automatic check_key(input logic [KW-1:0] expected, input logic [KW-1:0] actual,
                             input string what);
        if (actual !== expected) begin
            $display("CHECK FAILED at %0t ns: %s expected %h, got %h",
                     $time, what, expected, actual);
            end_with_failure();
        end
    endtask

    task automatic check_flag(input logic expected, input logic actual, input string what);
        if (actual !== expected) begin
            $display("CHECK FAILED at %0t ns: %s expected %b, got %b",
                     $time, what, expected, actual);
            end_with_failure();
        end
    endtask

    task automatic check_cycle(input int expected, input int actual, input string what);
        if (actual != expected) begin
            $display("CHECK FAILED at %0t ns: %s expected %0d, got %0d",
                     $time, what, expected, actual);
            end_with_failure();
        end
    endtask

    // Top three bits of the low word of key times the way's odd constant
    function automatic logic [AW-1:0] way_index(input logic [KW-1:0] key, input int way);
        logic [31:0] mult;
        logic [31:0] prod;
        case (way)
            0: mult = 32'h9E3779B1;
            1: mult = 32'h85EBCA77;
            2: mult = 32'hC2B2AE3D;
            default: mult = 32'h27D4EB2F;
        endcase
        prod = key * mult;
        return prod[31:29];
    endfunction

    function automatic logic [QW-1:0] model_lookup(input logic [KW-1:0] key);
        logic [AW-1:0] idx;
        for (int w = 0; w < NW; w++) begin
            idx = way_index(key, w);
            if (model_valid[w][idx] && model_key[w][idx] == key) begin
                return model_qid[w][idx];
            end
        end
        return flow_table_pkg::QID_DROP;
    endfunction

    // Update first hit, else fill first empty way; returns the expected full flag
    function automatic logic model_place(input logic [KW-1:0] key, input logic [QW-1:0] qid);
        logic [AW-1:0] idx;
        for (int w = 0; w < NW; w++) begin
            idx = way_index(key, w);
            if (model_valid[w][idx] && model_key[w][idx] == key) begin
                model_qid[w][idx] = qid;
                return 1'b0;
            end
        end
        for (int w = 0; w < NW; w++) begin
            idx = way_index(key, w);
            if (!model_valid[w][idx]) begin
                model_valid[w][idx] = 1'b1;
                model_key[w][idx]   = key;
                model_qid[w][idx]   = qid;
                return 1'b0;
            end
        end
        return 1'b1;
    endfunction

    function automatic logic [KW-1:0] pick_key();
        int pos;
        pos = $unsigned($random(seed)) % POOL_SIZE;
        return pool[pos];
    endfunction

    // Called 2 ns after an edge; the lookup is sampled at the next edge
    task automatic issue_lookup(input logic [KW-1:0] key);
        lookup_valid = 1'b1;
        lookup_key   = key;
        exp_key.push_back(key);
        exp_qid.push_back(model_lookup(key));
        exp_cycle.push_back(cycle + 3);
        @(posedge clk);
        #2;
    endtask

    task automatic drain_lookups();
        lookup_valid = 1'b0;
        while (exp_key.size() != 0) begin
            @(negedge clk);
        end
        @(posedge clk);
        #2;
    endtask

    task automatic issue_place(input logic [KW-1:0] key, input logic [QW-1:0] qid);
        logic exp_full;
        int   waited;
        while (!ctrl_ready) begin
            @(posedge clk);
            #2;
        end
        ctrl_valid = 1'b1;
        ctrl_key   = key;
        ctrl_qid   = qid;
        @(posedge clk);
        #2;
        ctrl_valid = 1'b0;
        exp_full = model_place(key, qid);
        waited = 0;
        do begin
            @(negedge clk);
            waited = waited + 1;
        end while (!ctrl_done && waited < 8);
        if (!ctrl_done) begin
            $display("Placement of key %h never signalled ctrl_done", key);
            end_with_failure();
        end
        check_flag(exp_full, ctrl_full, "ctrl_full");
        if (exp_full) begin
            full_count = full_count + 1;
        end
        @(posedge clk);
        #2;
    endtask

    // Results are sampled mid-cycle, away from the edges
    always @(negedge clk) begin
        if (!rst) begin
            if (result_valid) begin
                if (exp_key.size() == 0) begin
                    $display("A lookup result appeared with no lookup outstanding");
                    end_with_failure();
                end else begin
                    check_key(exp_key.pop_front(), result_key, "result_key");
                    check_qid(exp_qid.pop_front(), result_qid, "result_qid");
                    check_cycle(exp_cycle.pop_front(), cycle, "result cycle");
                end
            end else if (exp_cycle.size() != 0 && cycle > exp_cycle[0]) begin
                $display("A lookup result did not arrive on time");
                end_with_failure();
            end
        end
    end

    initial begin
        #(NUM_TESTS * 10 * CLK_PERIOD + RESET_CYCLES * CLK_PERIOD);
        $display("Timeout: the run did not finish in time, stopped at %0t ns", $time);
        end_with_failure();
    end

    initial begin
        int burst;
        seed         = 32'ha0f0_8133;
        rst          = 1'b1;
        lookup_valid = 1'b0;
        lookup_key   = '0;
        ctrl_valid   = 1'b0;
        ctrl_key     = '0;
        ctrl_qid     = '0;
        for (int w = 0; w < NW; w++) begin
            for (int r = 0; r < flow_table_pkg::FT_DEPTH; r++) begin
                model_valid[w][r] = 1'b0;
                model_key[w][r]   = '0;
                model_qid[w][r]   = '0;
            end
        end
        for (int i = 0; i < POOL_SIZE; i++) begin
            pool[i] = $random(seed);
        end
        repeat (RESET_CYCLES) @(posedge clk);
        #2;
        rst = 1'b0;

        // Empty table misses everywhere
        for (int i = 0; i < 16; i++) begin
            issue_lookup(pool[i]);
        end
        drain_lookups();

        for (int n = 0; n < NUM_ROUNDS; n++) begin
            issue_place(pick_key(), 8'($random(seed)));
            issue_lookup(ctrl_key);
            burst = $unsigned($random(seed)) % 4;
            for (int i = 0; i < burst; i++) begin
                issue_lookup(pick_key());
            end
            drain_lookups();
        end

        $display("Placements reporting a full set: %0d", full_count);
        if (full_count == 0) begin
            $display("No placement ever found its set full");
            end_with_failure();
        end
        if (error_count == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* flow_table.f */
design/flow_table_pkg.sv
design/flow_table_if.sv
design/key_hasher.sv
design/flow_table_ram.sv
design/lookup_matcher.sv
design/flow_placer.sv
design/flow_table.sv
tb/flow_table_checker.sv
tb/flow_table_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the flow table testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ns \
    -f flow_table.f --top-module flow_table_tb \
    --Mdir obj_dir -o flow_table_sim > build.log 2>&1
if [ $? -ne 0 ]; then
    cat build.log
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/flow_table_sim > sim.log 2>&1
sim_status=$?
cat sim.log
if [ $sim_status -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi

if grep -q '^\*\* PASS \*\*$' sim.log; then
    exit 0
fi
exit 1
